// ==== data_ram.sv ====
// ========================================
// byte-masked data RAM behind a four-phase
// req/ack responder with fixed wait states
// ========================================
`timescale 1ns/1ps
`include "lsu_settings.svh"

module data_ram (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   req_i,
    input  lsu_bus_pkg::ram_req_t  bus_i,
    output logic                   ack_o,
    output logic [`LSU_XLEN-1:0]   rdata_o
);

    localparam int IDX_W = $clog2(`LSU_RAM_WORDS);
    localparam int CNT_W = $clog2(`LSU_RAM_WAIT + 2);

    logic [`LSU_XLEN-1:0] mem [`LSU_RAM_WORDS];
    logic [IDX_W-1:0]     idx;
    logic [CNT_W-1:0]     wait_q;
    logic                 ack_q;
    logic                 access;
    logic [`LSU_XLEN-1:0] rdata_q;

    // upper doubleword address bits fold onto the array
    assign idx    = bus_i.addr[IDX_W-1:0];
    assign access = req_i && !ack_q && (wait_q == CNT_W'(`LSU_RAM_WAIT));

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wait_q <= '0;
            ack_q  <= 1'b0;
        end else if (access) begin
            ack_q  <= 1'b1;
            wait_q <= '0;
        end else if (req_i && !ack_q) begin
            wait_q <= wait_q + 1'b1;
        end else if (!req_i) begin
            // requester has let go, finish the handshake
            ack_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (access) begin
            rdata_q <= mem[idx];
            if (bus_i.we) begin
                for (int b = 0; b < `LSU_XLEN / 8; b++) begin
                    if (bus_i.wmask[b]) begin
                        mem[idx][b*8 +: 8] <= bus_i.wdata[b*8 +: 8];
                    end
                end
            end
        end
    end

    assign ack_o   = ack_q;
    assign rdata_o = rdata_q;

endmodule

// ==== load_store.sv ====
// ========================================
// lane alignment for one doubleword access
// store placement and mask, load extension
// ========================================
`timescale 1ns/1ps
`include "lsu_settings.svh"

module load_store (
    input  lsu_bus_pkg::ls_op_e      op_i,
    // byte offset inside the doubleword
    input  logic [2:0]               addr_i,
    input  logic [`LSU_XLEN-1:0]     store_val_i,
    input  logic [`LSU_XLEN-1:0]     ram_rdata_i,
    output logic [`LSU_XLEN-1:0]     ram_wdata_o,
    output lsu_bus_pkg::byte_mask_t  wmask_o,
    output logic [`LSU_XLEN-1:0]     load_val_o
);

    import lsu_bus_pkg::*;

    logic [2:0]  byte_sel;
    logic [1:0]  half_sel;
    logic        word_sel;
    logic [7:0]  rd_byte;
    logic [15:0] rd_half;
    logic [31:0] rd_word;

    // bits below the access size are ignored
    assign byte_sel = addr_i[2:0];
    assign half_sel = addr_i[2:1];
    assign word_sel = addr_i[2];

    // store side: move the low bits of the value onto the addressed lanes
    always_comb begin
        case (op_i)
            LS_SB: begin
                ram_wdata_o = {{(`LSU_XLEN-8){1'b0}}, store_val_i[7:0]}
                              << {byte_sel, 3'b000};
                wmask_o     = 8'b0000_0001 << byte_sel;
            end
            LS_SH: begin
                ram_wdata_o = {{(`LSU_XLEN-16){1'b0}}, store_val_i[15:0]}
                              << {half_sel, 4'b0000};
                wmask_o     = 8'b0000_0011 << {half_sel, 1'b0};
            end
            LS_SW: begin
                ram_wdata_o = {{(`LSU_XLEN-32){1'b0}}, store_val_i[31:0]}
                              << {word_sel, 5'b00000};
                wmask_o     = 8'b0000_1111 << {word_sel, 2'b00};
            end
            LS_SD: begin
                ram_wdata_o = store_val_i;
                wmask_o     = 8'b1111_1111;
            end
            default: begin
                // loads and plain alu records never write
                ram_wdata_o = '0;
                wmask_o     = '0;
            end
        endcase
    end

    // load side: pick the addressed piece out of the read doubleword
    assign rd_byte = ram_rdata_i[{byte_sel, 3'b000} +: 8];
    assign rd_half = ram_rdata_i[{half_sel, 4'b0000} +: 16];
    assign rd_word = word_sel ? ram_rdata_i[63:32] : ram_rdata_i[31:0];

    always_comb begin
        case (op_i)
            LS_LB: begin
                load_val_o = {{(`LSU_XLEN-8){rd_byte[7]}}, rd_byte};
            end
            LS_LH: begin
                load_val_o = {{(`LSU_XLEN-16){rd_half[15]}}, rd_half};
            end
            LS_LW: begin
                load_val_o = {{(`LSU_XLEN-32){rd_word[31]}}, rd_word};
            end
            LS_LBU: begin
                load_val_o = {{(`LSU_XLEN-8){1'b0}}, rd_byte};
            end
            LS_LHU: begin
                load_val_o = {{(`LSU_XLEN-16){1'b0}}, rd_half};
            end
            LS_LWU: begin
                load_val_o = {{(`LSU_XLEN-32){1'b0}}, rd_word};
            end
            LS_LD: begin
                load_val_o = ram_rdata_i;
            end
            default: begin
                load_val_o = '0;
            end
        endcase
    end

endmodule

// ==== lsu_bus_pkg.sv ====
// ========================================
// memory-side types: access kinds and the
// request bundle sent to the data RAM
// ========================================
`include "lsu_settings.svh"

package lsu_bus_pkg;

    // load/store access kinds decoded upstream
    typedef enum logic [3:0] {
        LS_NONE,
        LS_SB,
        LS_SH,
        LS_SW,
        LS_SD,
        LS_LB,
        LS_LH,
        LS_LW,
        LS_LBU,
        LS_LHU,
        LS_LWU,
        LS_LD
    } ls_op_e;

    // doubleword index, byte offset bits dropped
    typedef logic [`LSU_ADDR_W-4:0] dw_addr_t;

    // one enable per byte lane
    typedef logic [`LSU_XLEN/8-1:0] byte_mask_t;

    typedef struct packed {
        logic                 we;
        dw_addr_t             addr;
        logic [`LSU_XLEN-1:0] wdata;
        byte_mask_t           wmask;
    } ram_req_t;

endpackage

// ==== lsu_pipe_pkg.sv ====
// ========================================
// pipeline-side records entering and
// leaving the memory stage
// ========================================
`include "lsu_settings.svh"

package lsu_pipe_pkg;

    // replaces one-hot type bits from decode
    typedef enum logic [1:0] {
        CLS_ALU,
        CLS_LOAD,
        CLS_STORE
    } inst_class_e;

    typedef struct packed {
        inst_class_e            cls;
        lsu_bus_pkg::ls_op_e    op;
        logic [`LSU_ADDR_W-1:0] addr;
        logic                   rd_ena;
        logic [4:0]             rd_addr;
        // alu result, or the store value for stores
        logic [`LSU_XLEN-1:0]   rd_data;
        logic [`LSU_ADDR_W-1:0] pc;
        logic [31:0]            inst;
    } mem_in_t;

    typedef struct packed {
        logic                   rd_ena;
        logic [4:0]             rd_addr;
        logic [`LSU_XLEN-1:0]   rd_data;
        logic [`LSU_ADDR_W-1:0] pc;
        logic [31:0]            inst;
    } wb_t;

endpackage

// ==== lsu_settings.svh ====
// ========================================
// build-time sizes for the memory stage
// include wherever the widths are needed
// ========================================
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// integer register and data bus width
`define LSU_XLEN 64

// byte address width seen by the stage
`define LSU_ADDR_W 32

// data RAM depth in doublewords
`define LSU_RAM_WORDS 256

// cycles the RAM holds off ack after it sees req
`define LSU_RAM_WAIT 2

`endif

// ==== mem_stage.sv ====
// ========================================
// memory stage control: takes one record,
// runs the four-phase RAM request, stalls
// upstream and registers the writeback
// ========================================
`timescale 1ns/1ps
`include "lsu_settings.svh"

module mem_stage (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  logic                     in_valid_i,
    input  lsu_pipe_pkg::mem_in_t    in_i,
    output logic                     stall_o,
    output logic                     ram_req_o,
    output lsu_bus_pkg::ram_req_t    ram_bus_o,
    input  logic                     ram_ack_i,
    input  logic [`LSU_XLEN-1:0]     ram_rdata_i,
    output logic                     wb_valid_o,
    output lsu_pipe_pkg::wb_t        wb_o
);

    import lsu_pipe_pkg::*;

    typedef enum logic [1:0] {IDLE, REQ, RELEASE, DONE} state_e;

    state_e               state_q;
    state_e               accept_state;
    mem_in_t              rec_q;
    logic                 req_q;
    logic                 accept;
    logic [`LSU_XLEN-1:0] load_val;
    logic [`LSU_XLEN-1:0] load_q;
    wb_t                  wb_next;
    wb_t                  wb_q;
    logic                 wb_valid_q;

    // alu records finishing in DONE do not hold off the next one
    assign stall_o = (state_q == REQ) || (state_q == RELEASE)
                     || ((state_q == DONE) && (rec_q.cls != CLS_ALU));
    assign accept  = in_valid_i && !stall_o;
    assign accept_state = (in_i.cls == CLS_ALU) ? DONE : REQ;

    load_store u_load_store (
        .op_i        (rec_q.op),
        .addr_i      (rec_q.addr[2:0]),
        .store_val_i (rec_q.rd_data),
        .ram_rdata_i (ram_rdata_i),
        .ram_wdata_o (ram_bus_o.wdata),
        .wmask_o     (ram_bus_o.wmask),
        .load_val_o  (load_val)
    );

    assign ram_bus_o.we   = (rec_q.cls == CLS_STORE);
    assign ram_bus_o.addr = rec_q.addr[`LSU_ADDR_W-1:3];
    assign ram_req_o      = req_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q    <= IDLE;
            req_q      <= 1'b0;
            wb_valid_q <= 1'b0;
            wb_q       <= '0;
        end else begin
            wb_valid_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (accept) begin
                        state_q <= accept_state;
                    end
                end
                REQ: begin
                    // raise req only once the previous ack has dropped
                    if (!req_q && !ram_ack_i) begin
                        req_q <= 1'b1;
                    end else if (req_q && ram_ack_i) begin
                        req_q   <= 1'b0;
                        state_q <= RELEASE;
                    end
                end
                RELEASE: begin
                    if (!ram_ack_i) begin
                        state_q <= DONE;
                    end
                end
                default: begin
                    wb_valid_q <= 1'b1;
                    wb_q       <= wb_next;
                    state_q    <= accept ? accept_state : IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            rec_q <= in_i;
        end
        // read data is valid while ack is high
        if ((state_q == REQ) && req_q && ram_ack_i) begin
            load_q <= load_val;
        end
    end

    always_comb begin
        wb_next.rd_ena  = rec_q.rd_ena && (rec_q.cls != CLS_STORE);
        wb_next.rd_addr = rec_q.rd_addr;
        wb_next.rd_data = (rec_q.cls == CLS_LOAD) ? load_q : rec_q.rd_data;
        wb_next.pc      = rec_q.pc;
        wb_next.inst    = rec_q.inst;
    end

    assign wb_valid_o = wb_valid_q;
    assign wb_o       = wb_q;

endmodule

// ==== mem_subsys_top.sv ====
// ========================================
// memory stage wired to its data RAM
// ========================================
`timescale 1ns/1ps
`include "lsu_settings.svh"

module mem_subsys_top (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   in_valid_i,
    input  lsu_pipe_pkg::mem_in_t  in_i,
    output logic                   stall_o,
    output logic                   wb_valid_o,
    output lsu_pipe_pkg::wb_t      wb_o
);

    import lsu_bus_pkg::*;

    logic                 ram_req;
    ram_req_t             ram_bus;
    logic                 ram_ack;
    logic [`LSU_XLEN-1:0] ram_rdata;

    mem_stage u_mem_stage (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .in_valid_i  (in_valid_i),
        .in_i        (in_i),
        .stall_o     (stall_o),
        .ram_req_o   (ram_req),
        .ram_bus_o   (ram_bus),
        .ram_ack_i   (ram_ack),
        .ram_rdata_i (ram_rdata),
        .wb_valid_o  (wb_valid_o),
        .wb_o        (wb_o)
    );

    data_ram u_data_ram (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .req_i   (ram_req),
        .bus_i   (ram_bus),
        .ack_o   (ram_ack),
        .rdata_o (ram_rdata)
    );

endmodule

// ==== run.sh ====
#!/bin/sh
# compile and run the memory stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f \
    --top-module tb_mem_subsys \
    -Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

// ==== tb_mem_subsys.sv ====
// ========================================
// directed testbench for the memory stage
// checks writeback against a doubleword
// model of the data RAM, run via vlog.f
// ========================================
`timescale 1ns/1ps
`include "lsu_settings.svh"

module tb_mem_subsys;

    import lsu_bus_pkg::*;
    import lsu_pipe_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    // cycle bound for one transaction
    localparam int TRANS_BOUND  = 40;
    // records sent by all tests together
    localparam int TRANS_TOTAL  = 2 + 8 + 51 + 29 + 4 + 3;
    localparam int WATCHDOG_NS  = (TRANS_TOTAL * TRANS_BOUND + 2 * RESET_CYCLES) * CLK_PERIOD;

    logic    clk;
    logic    reset;
    logic    in_valid;
    mem_in_t in_rec;
    logic    stall;
    logic    wb_valid;
    wb_t     wb;

    logic [`LSU_XLEN-1:0] ref_mem [`LSU_RAM_WORDS];
    int     err_count;
    int     test_err_start;
    int     pass_count;
    int     fail_count;
    int     serial;
    integer seed;

    mem_subsys_top dut (
        .clk_i      (clk),
        .reset_i    (reset),
        .in_valid_i (in_valid),
        .in_i       (in_rec),
        .stall_o    (stall),
        .wb_valid_o (wb_valid),
        .wb_o       (wb)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [63:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    // access size in bytes
    function automatic int access_size(input ls_op_e op);
        case (op)
            LS_SB, LS_LB, LS_LBU: return 1;
            LS_SH, LS_LH, LS_LHU: return 2;
            LS_SW, LS_LW, LS_LWU: return 4;
            default: return 8;
        endcase
    endfunction

    // first byte lane, address bits below the size dropped
    function automatic int lane_base(input ls_op_e op, input logic [31:0] addr);
        return int'(addr[2:0]) & ~(access_size(op) - 1);
    endfunction

    function automatic int dw_index(input logic [31:0] addr);
        return int'(addr[31:3]) % `LSU_RAM_WORDS;
    endfunction

    task automatic model_store(input ls_op_e op, input logic [31:0] addr,
                               input logic [63:0] val);
        int base;
        int size;
        int dw;
        base = lane_base(op, addr);
        size = access_size(op);
        dw = dw_index(addr);
        for (int i = 0; i < size; i++) begin
            ref_mem[dw][(base + i) * 8 +: 8] = val[i * 8 +: 8];
        end
    endtask

    function automatic logic [63:0] model_load(input ls_op_e op, input logic [31:0] addr);
        logic [63:0] dword;
        logic [63:0] val;
        int base;
        int size;
        dword = ref_mem[dw_index(addr)];
        base = lane_base(op, addr);
        size = access_size(op);
        val = '0;
        for (int i = 0; i < size; i++) begin
            val[i * 8 +: 8] = dword[(base + i) * 8 +: 8];
        end
        // signed loads copy the top bit upward
        if (!(op inside {LS_LBU, LS_LHU, LS_LWU}) && size < 8 && val[size * 8 - 1]) begin
            for (int i = size * 8; i < 64; i++) begin
                val[i] = 1'b1;
            end
        end
        return val;
    endfunction

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        assert (got === exp) else begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic make_rec(input inst_class_e cls, input ls_op_e op, input logic [31:0] addr,
                            input logic [63:0] data, output mem_in_t rec);
        serial++;
        rec.cls     = cls;
        rec.op      = op;
        rec.addr    = addr;
        // odd and even records alternate the write enable
        rec.rd_ena  = serial[0];
        rec.rd_addr = 5'(serial);
        rec.rd_data = data;
        rec.pc      = 32'h8000_0000 + 32'(serial * 4);
        rec.inst    = $random(seed);
    endtask

    task automatic check_wb(input wb_t got, input mem_in_t rec, input logic [63:0] exp_data);
        check_val("wb_o.rd_ena", 64'(got.rd_ena), 64'(rec.rd_ena && rec.cls != CLS_STORE));
        check_val("wb_o.rd_addr", 64'(got.rd_addr), 64'(rec.rd_addr));
        check_val("wb_o.rd_data", got.rd_data, exp_data);
        check_val("wb_o.pc", 64'(got.pc), 64'(rec.pc));
        check_val("wb_o.inst", 64'(got.inst), 64'(rec.inst));
    endtask

    // hold the record until the stage takes it, then release the input
    task automatic send_rec(input mem_in_t rec, output bit stall_seen);
        int waits;
        stall_seen = 1'b0;
        waits = 0;
        @(negedge clk);
        in_valid = 1'b1;
        in_rec   = rec;
        while (stall && waits < TRANS_BOUND) begin
            stall_seen = 1'b1;
            waits++;
            @(negedge clk);
        end
        assert (!stall) else begin
            $display("Error at %0t: record was never accepted by the stage", $time);
            err_count++;
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_wb(output wb_t got, inout bit stall_seen);
        int cycles;
        cycles = 0;
        while (!wb_valid && cycles < TRANS_BOUND) begin
            if (stall) begin
                stall_seen = 1'b1;
            end
            cycles++;
            @(negedge clk);
        end
        got = wb;
        assert (wb_valid) else begin
            $display("Error at %0t: no writeback within %0d cycles", $time, TRANS_BOUND);
            err_count++;
        end
    endtask

    task automatic run_trans(input inst_class_e cls, input ls_op_e op, input logic [31:0] addr,
                             input logic [63:0] data, output bit stall_seen);
        mem_in_t     rec;
        wb_t         got;
        logic [63:0] exp_data;
        make_rec(cls, op, addr, data, rec);
        exp_data = (cls == CLS_LOAD) ? model_load(op, addr) : data;
        send_rec(rec, stall_seen);
        wait_wb(got, stall_seen);
        check_wb(got, rec, exp_data);
        if (cls == CLS_STORE) begin
            model_store(op, addr, data);
        end
    endtask

    task automatic begin_test();
        test_err_start = err_count;
    endtask

    task automatic finish_test(input string name);
        if (err_count == test_err_start) begin
            pass_count++;
            $display("test %s: passed", name);
        end else begin
            fail_count++;
            $display("test %s: failed with %0d errors", name, err_count - test_err_start);
        end
    endtask

    task automatic apply_reset();
        begin_test();
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_val("wb_valid_o", 64'(wb_valid), 64'h0);
        check_val("stall_o", 64'(stall), 64'h0);
        check_val("wb_o.rd_ena", 64'(wb.rd_ena), 64'h0);
        check_val("wb_o.rd_addr", 64'(wb.rd_addr), 64'h0);
        check_val("wb_o.rd_data", wb.rd_data, 64'h0);
        check_val("wb_o.pc", 64'(wb.pc), 64'h0);
        check_val("wb_o.inst", 64'(wb.inst), 64'h0);
        finish_test("reset");
    endtask

    task automatic alu_passthrough();
        bit stall_seen;
        begin_test();
        for (int i = 0; i < 2; i++) begin
            run_trans(CLS_ALU, LS_NONE, 32'h0, rand64(), stall_seen);
            assert (!stall_seen) else begin
                $display("Error at %0t: stall rose for an ALU record", $time);
                err_count++;
            end
        end
        finish_test("alu_passthrough");
    endtask

    task automatic dword_roundtrip();
        logic [31:0] addrs [4];
        bit          stall_seen;
        addrs = '{32'h000, 32'h008, 32'h3f8, 32'h7f8};
        begin_test();
        foreach (addrs[i]) begin
            run_trans(CLS_STORE, LS_SD, addrs[i], rand64(), stall_seen);
            run_trans(CLS_LOAD, LS_LD, addrs[i], 64'h0, stall_seen);
        end
        finish_test("dword_roundtrip");
    endtask

    // partial stores at every byte offset, each read back as a whole doubleword
    task automatic lane_stores();
        bit stall_seen;
        begin_test();
        run_trans(CLS_STORE, LS_SD, 32'h100, rand64(), stall_seen);
        for (int off = 0; off < 8; off++) begin
            run_trans(CLS_STORE, LS_SB, 32'h100 + 32'(off), rand64(), stall_seen);
            run_trans(CLS_LOAD, LS_LD, 32'h100, 64'h0, stall_seen);
        end
        run_trans(CLS_STORE, LS_SD, 32'h140, rand64(), stall_seen);
        for (int off = 0; off < 8; off++) begin
            run_trans(CLS_STORE, LS_SH, 32'h140 + 32'(off), rand64(), stall_seen);
            run_trans(CLS_LOAD, LS_LD, 32'h140, 64'h0, stall_seen);
        end
        run_trans(CLS_STORE, LS_SD, 32'h180, rand64(), stall_seen);
        for (int off = 0; off < 8; off++) begin
            run_trans(CLS_STORE, LS_SW, 32'h180 + 32'(off), rand64(), stall_seen);
            run_trans(CLS_LOAD, LS_LD, 32'h180, 64'h0, stall_seen);
        end
        finish_test("lane_stores");
    endtask

    task automatic load_extension();
        bit stall_seen;
        begin_test();
        // every byte, half and word has its top bit set
        run_trans(CLS_STORE, LS_SD, 32'h1c0, 64'h8899_aabb_ccdd_eeff, stall_seen);
        for (int off = 0; off < 8; off++) begin
            run_trans(CLS_LOAD, LS_LB, 32'h1c0 + 32'(off), 64'h0, stall_seen);
            run_trans(CLS_LOAD, LS_LBU, 32'h1c0 + 32'(off), 64'h0, stall_seen);
        end
        for (int off = 0; off < 8; off += 2) begin
            run_trans(CLS_LOAD, LS_LH, 32'h1c0 + 32'(off), 64'h0, stall_seen);
            run_trans(CLS_LOAD, LS_LHU, 32'h1c0 + 32'(off), 64'h0, stall_seen);
        end
        for (int off = 0; off < 8; off += 4) begin
            run_trans(CLS_LOAD, LS_LW, 32'h1c0 + 32'(off), 64'h0, stall_seen);
            run_trans(CLS_LOAD, LS_LWU, 32'h1c0 + 32'(off), 64'h0, stall_seen);
        end
        finish_test("load_extension");
    endtask

    task automatic store_writeback();
        bit stall_seen;
        begin_test();
        run_trans(CLS_STORE, LS_SB, 32'h201, rand64(), stall_seen);
        run_trans(CLS_STORE, LS_SH, 32'h212, rand64(), stall_seen);
        run_trans(CLS_STORE, LS_SW, 32'h224, rand64(), stall_seen);
        run_trans(CLS_STORE, LS_SD, 32'h238, rand64(), stall_seen);
        finish_test("store_writeback");
    endtask

    // second record waits at the input while the load is open
    task automatic load_stall_hold();
        mem_in_t ld_rec;
        mem_in_t alu_rec;
        wb_t     got;
        int      cycles;
        bit      stall_seen;
        begin_test();
        run_trans(CLS_STORE, LS_SD, 32'h300, rand64(), stall_seen);
        make_rec(CLS_LOAD, LS_LD, 32'h300, 64'h0, ld_rec);
        make_rec(CLS_ALU, LS_NONE, 32'h0, rand64(), alu_rec);
        @(negedge clk);
        check_val("stall_o", 64'(stall), 64'h0);
        in_valid = 1'b1;
        in_rec   = ld_rec;
        @(negedge clk);
        in_rec = alu_rec;
        cycles = 0;
        while (!wb_valid && cycles < TRANS_BOUND) begin
            assert (stall) else begin
                $display("Error at %0t: stall low while the load was still open", $time);
                err_count++;
            end
            cycles++;
            @(negedge clk);
        end
        got = wb;
        check_wb(got, ld_rec, model_load(LS_LD, 32'h300));
        // the held ALU record goes in on the next edge
        @(negedge clk);
        in_valid = 1'b0;
        wait_wb(got, stall_seen);
        check_wb(got, alu_rec, alu_rec.rd_data);
        finish_test("load_stall_hold");
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        in_valid   = 1'b0;
        in_rec     = '0;
        seed       = 32'h6bf8_d79f;
        err_count  = 0;
        pass_count = 0;
        fail_count = 0;
        serial     = 0;
        apply_reset();
        alu_passthrough();
        dword_roundtrip();
        lane_stores();
        load_extension();
        store_writeback();
        load_stall_hold();
        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 pass_count, fail_count, err_count);
        if (fail_count == 0 && err_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+.
lsu_bus_pkg.sv
lsu_pipe_pkg.sv
load_store.sv
mem_stage.sv
data_ram.sv
mem_subsys_top.sv
tb_mem_subsys.sv
